/* source/emesh_pkg.sv */
package emesh_pkg;

   //##################################################
   // bus widths and axi field types

   localparam int S_IDW = 12;   // axi id width
   localparam int AW    = 32;   // mesh address
   localparam int DW    = 32;   // mesh data

   typedef logic [S_IDW-1:0] axi_id_t;
   typedef logic [AW-1:0]    axi_addr_t;
   typedef logic [7:0]       axi_len_t;
   typedef logic [2:0]       axi_size_t;    // 0=byte, 1=half, 2=word
   typedef logic [1:0]       axi_burst_t;
   typedef logic [DW-1:0]    axi_data_t;
   typedef logic [DW/8-1:0]  axi_strb_t;

   // fixed and wrap bursts both hold the address
   localparam axi_burst_t AXI_BURST_INCR = 2'b01;

   //##################################################
   // mesh addressing

   localparam logic [11:0] CHIP_ID     = 12'h999;
   localparam logic [3:0]  EGROUP_RR   = 4'hD;                  // read-response group
   localparam logic [15:0] RETURN_ADDR = {CHIP_ID, EGROUP_RR};  // upper half of srcaddr

   // request queues
   localparam int FIFO_DEPTH     = 4;
   localparam int FIFO_PTR_W     = $clog2(FIFO_DEPTH);
   localparam int FIFO_SPACE_MIN = 2;   // free slots before a write beat is taken

   //##################################################
   // transaction formats

   typedef struct packed {
      logic          write;
      logic [1:0]    datamode;   // same coding as axi size
      logic [3:0]    ctrlmode;
      logic [AW-1:0] dstaddr;
      logic [DW-1:0] data;
      logic [AW-1:0] srcaddr;    // return address, reads only
   } emesh_packet_t;             // 103 bits

   // read request before it becomes a packet
   typedef struct packed {
      logic [1:0]    datamode;
      logic [AW-1:0] dstaddr;
      logic [AW-1:0] srcaddr;
   } read_req_t;                 // 66 bits

endpackage

/* source/axi_write_packetizer.sv */
`timescale 1ns/1ps

module axi_write_packetizer
(
   input  logic                     s_axi_aclk,
   input  logic                     s_axi_aresetn,
   input  emesh_pkg::axi_id_t       awid,
   input  emesh_pkg::axi_addr_t     awaddr,
   input  emesh_pkg::axi_size_t     awsize,
   input  emesh_pkg::axi_burst_t    awburst,
   input  logic                     awvalid,
   output logic                     awready,
   input  emesh_pkg::axi_data_t     wdata,
   input  emesh_pkg::axi_strb_t     wstrb,
   input  logic                     wlast,
   input  logic                     wvalid,
   output logic                     wready,
   output emesh_pkg::axi_id_t       bid,
   output logic                     bvalid,
   input  logic                     bready,
   input  logic                     space_ok,   // write queue level
   output logic                     push,
   output emesh_pkg::emesh_packet_t pkt
);

   import emesh_pkg::*;

   logic       write_active;   // aw taken, last beat not yet
   logic       aw_hs;
   logic       w_hs;
   logic       last_wr_beat;
   axi_addr_t  wr_addr;        // word address of the next beat
   logic [1:0] wr_mode;
   axi_burst_t wr_burst;
   logic [1:0] lane;           // lowest enabled byte lane
   logic       s1_valid;
   axi_data_t  s1_data;
   axi_addr_t  s1_addr;
   logic [1:0] s1_mode;

   assign aw_hs        = awvalid & awready;
   assign w_hs         = wvalid & wready;
   assign last_wr_beat = w_hs & wlast;

   // stall when both pipe stages already hold beats for the queue
   assign wready = write_active & space_ok & ~(s1_valid & push);

   //##################################################
   // address and response channels

   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         awready      <= 1'b1;
         write_active <= 1'b0;
      end
      else
      begin
         if (aw_hs)
            awready <= 1'b0;
         else if (!awready && !write_active && !bvalid)
            awready <= 1'b1;   // burst done, response gone
         if (aw_hs)
            write_active <= 1'b1;
         else if (last_wr_beat)
            write_active <= 1'b0;
      end
   end

   always_ff @(posedge s_axi_aclk)
   begin
      if (aw_hs)
      begin
         bid      <= awid;
         wr_addr  <= awaddr;
         wr_mode  <= awsize[1:0];
         wr_burst <= awburst;
      end
      else if (w_hs && wr_burst == AXI_BURST_INCR)
         wr_addr <= {wr_addr[AW-1:2] + 1'b1, 2'b00};   // next word
   end

   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
         bvalid <= 1'b0;
      else if (last_wr_beat)
         bvalid <= 1'b1;   // always okay
      else if (bready)
         bvalid <= 1'b0;
   end

   //##################################################
   // beat to packet, two stages

   always_comb
   begin
      if (wstrb[0])
         lane = 2'd0;
      else if (wstrb[1])
         lane = 2'd1;
      else if (wstrb[2])
         lane = 2'd2;
      else
         lane = 2'd3;   // empty strobe lands here too
   end

   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         s1_valid <= 1'b0;
         push     <= 1'b0;
      end
      else
      begin
         s1_valid <= w_hs;
         push     <= s1_valid;   // queue write two edges after the beat
      end
   end

   always_ff @(posedge s_axi_aclk)
   begin
      s1_data <= wdata >> {lane, 3'b000};     // selected lane down to bit 0
      s1_addr <= {wr_addr[AW-1:2], lane};
      s1_mode <= wr_mode;
   end

   always_ff @(posedge s_axi_aclk)
   begin
      pkt.write    <= 1'b1;
      pkt.datamode <= s1_mode;
      pkt.ctrlmode <= 4'b0000;
      pkt.dstaddr  <= s1_addr;
      pkt.data     <= s1_data;
      pkt.srcaddr  <= '0;        // no return path for writes
   end

endmodule

/* source/axi_read_packetizer.sv */
`timescale 1ns/1ps

module axi_read_packetizer
(
   input  logic                     s_axi_aclk,
   input  logic                     s_axi_aresetn,
   input  emesh_pkg::axi_id_t       arid,
   input  emesh_pkg::axi_addr_t     araddr,
   input  emesh_pkg::axi_len_t      arlen,
   input  emesh_pkg::axi_size_t     arsize,
   input  emesh_pkg::axi_burst_t    arburst,
   input  logic                     arvalid,
   output logic                     arready,
   output emesh_pkg::axi_id_t       rid,
   output emesh_pkg::axi_data_t     rdata,
   output logic                     rlast,
   output logic                     rvalid,
   input  logic                     rready,
   input  logic                     rx_access,   // read response from the mesh
   input  emesh_pkg::emesh_packet_t rx_packet,
   output logic                     push,
   output emesh_pkg::read_req_t     req
);

   import emesh_pkg::*;

   logic       read_active;   // one burst at a time
   logic       ractive_q;     // for the leading edge
   logic       rnext;         // non-last beat just accepted
   logic       ar_hs;
   logic       r_hs;
   logic       last_rd_beat;
   axi_addr_t  rd_addr;
   axi_len_t   rd_len;        // beats left after the current one
   logic [1:0] rd_mode;
   axi_burst_t rd_burst;

   assign ar_hs        = arvalid & arready;
   assign r_hs         = rvalid & rready;
   assign last_rd_beat = r_hs & rlast;

   //##################################################
   // address channel and request issue

   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         arready     <= 1'b0;
         read_active <= 1'b0;
         ractive_q   <= 1'b0;
         rnext       <= 1'b0;
         push        <= 1'b0;
      end
      else
      begin
         if (ar_hs)
            arready <= 1'b0;
         else if (!arready && !read_active)
            arready <= 1'b1;
         if (ar_hs)
            read_active <= 1'b1;
         else if (last_rd_beat)
            read_active <= 1'b0;
         ractive_q <= read_active;
         rnext     <= r_hs & ~rlast;
         push      <= (read_active & ~ractive_q) | rnext;   // first beat or next beat
      end
   end

   always_ff @(posedge s_axi_aclk)
   begin
      if (ar_hs)
      begin
         rid      <= arid;
         rd_addr  <= araddr;
         rd_len   <= arlen;
         rd_mode  <= arsize[1:0];
         rd_burst <= arburst;
      end
      else if (r_hs)
      begin
         rd_len <= rd_len - 1'b1;
         if (rd_burst == AXI_BURST_INCR)
            rd_addr <= {rd_addr[AW-1:2] + 1'b1, 2'b00};
      end
   end

   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
         rlast <= 1'b0;
      else if (ar_hs)
         rlast <= arlen == '0;     // single beat burst
      else if (r_hs)
         rlast <= rd_len == 8'd1;  // next beat is index arlen
   end

   always_ff @(posedge s_axi_aclk)
   begin
      req.datamode <= rd_mode;
      req.dstaddr  <= rd_addr;
      req.srcaddr  <= {RETURN_ADDR, 16'h0000};
   end

   //##################################################
   // read data channel

   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
         rvalid <= 1'b0;
      else if (rx_access)
         rvalid <= 1'b1;
      else if (rready)
         rvalid <= 1'b0;
   end

   // narrow reads copied across every lane
   always_ff @(posedge s_axi_aclk)
   begin
      if (rx_access)
      begin
         case (rd_mode)
            2'b00:   rdata <= {4{rx_packet.data[7:0]}};
            2'b01:   rdata <= {2{rx_packet.data[15:0]}};
            default: rdata <= rx_packet.data;
         endcase
      end
   end

endmodule

/* source/mesh_request_fifo.sv */
`timescale 1ns/1ps

module mesh_request_fifo
#(
   parameter type payload_t = emesh_pkg::emesh_packet_t
)
(
   input  logic     s_axi_aclk,
   input  logic     s_axi_aresetn,
   input  logic     push,
   input  payload_t din,
   input  logic     pop,
   output payload_t dout,        // head entry
   output logic     not_empty,
   output logic     space_ok
);

   import emesh_pkg::*;

   payload_t              mem [FIFO_DEPTH];
   logic [FIFO_PTR_W-1:0] wr_ptr;
   logic [FIFO_PTR_W-1:0] rd_ptr;
   logic [FIFO_PTR_W:0]   count;   // occupancy
   logic                  full;
   logic                  wr_en;
   logic                  rd_en;

   assign full      = count == (FIFO_PTR_W+1)'(FIFO_DEPTH);
   assign not_empty = count != '0;
   assign space_ok  = count <= (FIFO_PTR_W+1)'(FIFO_DEPTH - FIFO_SPACE_MIN);
   assign wr_en     = push & ~full;
   assign rd_en     = pop & not_empty;
   assign dout      = mem[rd_ptr];

   always_ff @(posedge s_axi_aclk)
   begin
      if (wr_en)
         mem[wr_ptr] <= din;
   end

   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (wr_en)
            wr_ptr <= wr_ptr + 1'b1;   // depth is a power of two
         if (rd_en)
            rd_ptr <= rd_ptr + 1'b1;
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // none, or both at once
         endcase
      end
   end

endmodule

/* source/mesh_tx_arbiter.sv */
`timescale 1ns/1ps

module mesh_tx_arbiter
(
   input  logic                     s_axi_aclk,
   input  logic                     s_axi_aresetn,
   input  emesh_pkg::emesh_packet_t wr_pkt,
   input  logic                     wr_valid,
   input  emesh_pkg::read_req_t     rd_req,
   input  logic                     rd_valid,
   input  logic                     tx_wait,    // mesh can't take a packet
   output logic                     wr_pop,
   output logic                     rd_pop,
   output logic                     tx_access,
   output emesh_pkg::emesh_packet_t tx_packet
);

   import emesh_pkg::*;

   emesh_packet_t rd_pkt;
   logic          slot_valid;   // tx_packet holds a packet

   // read request widened to a full packet
   always_comb
   begin
      rd_pkt          = '0;      // write, ctrlmode and data all zero
      rd_pkt.datamode = rd_req.datamode;
      rd_pkt.dstaddr  = rd_req.dstaddr;
      rd_pkt.srcaddr  = rd_req.srcaddr;
   end

   // reads first, nothing moves under wait
   assign rd_pop = rd_valid & ~tx_wait;
   assign wr_pop = wr_valid & ~rd_valid & ~tx_wait;

   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
         slot_valid <= 1'b0;
      else if (!tx_wait)
         slot_valid <= rd_valid | wr_valid;   // held while waiting
   end

   always_ff @(posedge s_axi_aclk)
   begin
      if (rd_pop)
         tx_packet <= rd_pkt;
      else if (wr_pop)
         tx_packet <= wr_pkt;
   end

   assign tx_access = slot_valid & ~tx_wait;

endmodule

/* source/esaxi_top.sv */
`timescale 1ns/1ps

module esaxi_top
(
   input  logic                     s_axi_aclk,
   input  logic                     s_axi_aresetn,
   // write address
   input  emesh_pkg::axi_id_t       awid,
   input  emesh_pkg::axi_addr_t     awaddr,
   input  emesh_pkg::axi_len_t      awlen,      // wlast ends the burst
   input  emesh_pkg::axi_size_t     awsize,
   input  emesh_pkg::axi_burst_t    awburst,
   input  logic                     awvalid,
   output logic                     awready,
   // write data and response
   input  emesh_pkg::axi_data_t     wdata,
   input  emesh_pkg::axi_strb_t     wstrb,
   input  logic                     wlast,
   input  logic                     wvalid,
   output logic                     wready,
   output emesh_pkg::axi_id_t       bid,
   output logic                     bvalid,
   input  logic                     bready,
   // read address
   input  emesh_pkg::axi_id_t       arid,
   input  emesh_pkg::axi_addr_t     araddr,
   input  emesh_pkg::axi_len_t      arlen,
   input  emesh_pkg::axi_size_t     arsize,
   input  emesh_pkg::axi_burst_t    arburst,
   input  logic                     arvalid,
   output logic                     arready,
   // read data
   output emesh_pkg::axi_id_t       rid,
   output emesh_pkg::axi_data_t     rdata,
   output logic                     rlast,
   output logic                     rvalid,
   input  logic                     rready,
   // mesh side
   output logic                     tx_access,
   output emesh_pkg::emesh_packet_t tx_packet,
   input  logic                     tx_wait,
   input  logic                     rxrr_access,
   input  emesh_pkg::emesh_packet_t rxrr_packet
);

   import emesh_pkg::*;

   logic          wr_push;
   emesh_packet_t wr_pkt;
   logic          wr_space_ok;
   emesh_packet_t wr_head;
   logic          wr_not_empty;
   logic          wr_pop;
   logic          rd_push;
   read_req_t     rd_req;
   read_req_t     rd_head;
   logic          rd_not_empty;
   logic          rd_pop;

   //##################################################
   // producers

   axi_write_packetizer wr_pktz_i (
      .s_axi_aclk    (s_axi_aclk),
      .s_axi_aresetn (s_axi_aresetn),
      .awid          (awid),
      .awaddr        (awaddr),
      .awsize        (awsize),
      .awburst       (awburst),
      .awvalid       (awvalid),
      .awready       (awready),
      .wdata         (wdata),
      .wstrb         (wstrb),
      .wlast         (wlast),
      .wvalid        (wvalid),
      .wready        (wready),
      .bid           (bid),
      .bvalid        (bvalid),
      .bready        (bready),
      .space_ok      (wr_space_ok),
      .push          (wr_push),
      .pkt           (wr_pkt)
   );

   axi_read_packetizer rd_pktz_i (
      .s_axi_aclk    (s_axi_aclk),
      .s_axi_aresetn (s_axi_aresetn),
      .arid          (arid),
      .araddr        (araddr),
      .arlen         (arlen),
      .arsize        (arsize),
      .arburst       (arburst),
      .arvalid       (arvalid),
      .arready       (arready),
      .rid           (rid),
      .rdata         (rdata),
      .rlast         (rlast),
      .rvalid        (rvalid),
      .rready        (rready),
      .rx_access     (rxrr_access),
      .rx_packet     (rxrr_packet),
      .push          (rd_push),
      .req           (rd_req)
   );

   //##################################################
   // queues and transmitter

   mesh_request_fifo #(.payload_t(emesh_packet_t)) wr_fifo_i (
      .s_axi_aclk    (s_axi_aclk),
      .s_axi_aresetn (s_axi_aresetn),
      .push          (wr_push),
      .din           (wr_pkt),
      .pop           (wr_pop),
      .dout          (wr_head),
      .not_empty     (wr_not_empty),
      .space_ok      (wr_space_ok)
   );

   // one read in flight, never fills
   mesh_request_fifo #(.payload_t(read_req_t)) rd_fifo_i (
      .s_axi_aclk    (s_axi_aclk),
      .s_axi_aresetn (s_axi_aresetn),
      .push          (rd_push),
      .din           (rd_req),
      .pop           (rd_pop),
      .dout          (rd_head),
      .not_empty     (rd_not_empty),
      .space_ok      ()
   );

   mesh_tx_arbiter tx_arb_i (
      .s_axi_aclk    (s_axi_aclk),
      .s_axi_aresetn (s_axi_aresetn),
      .wr_pkt        (wr_head),
      .wr_valid      (wr_not_empty),
      .rd_req        (rd_head),
      .rd_valid      (rd_not_empty),
      .tx_wait       (tx_wait),
      .wr_pop        (wr_pop),
      .rd_pop        (rd_pop),
      .tx_access     (tx_access),
      .tx_packet     (tx_packet)
   );

endmodule

/* verification/esaxi_top_tb.sv */
`timescale 1ns/1ps

module esaxi_top_tb;

   import emesh_pkg::*;

   logic          s_axi_aclk = 1'b0;
   logic          s_axi_aresetn;
   axi_id_t       awid, bid, arid, rid;
   logic [31:0]   awaddr, araddr, wdata, rdata;
   logic [7:0]    awlen, arlen;
   logic [2:0]    awsize, arsize;
   logic [1:0]    awburst, arburst;
   logic [3:0]    wstrb;
   logic          awvalid, awready, wlast, wvalid, wready, bvalid, bready;
   logic          arvalid, arready, rlast, rvalid, rready;
   logic          tx_access, tx_wait, rxrr_access;
   emesh_packet_t tx_packet, rxrr_packet;

   emesh_packet_t exp_wr[$];     // expected write packets in order
   emesh_packet_t exp_rd[$];     // read packets in order
   logic [31:0]   exp_rdata[$];
   int            n_checks = 0;
   int            n_errors = 0;
   int            test_base;     // errors before the current test
   int            cycle_cnt = 0;
   int            wr_in_flight = 0;
   int            wait_mode = 0;  // 0 open, 1 random, 2 held high
   logic          rd_outstanding = 1'b0;
   logic          read_first = 1'b0;
   logic          resp_pending = 1'b0;
   int            resp_delay;
   logic [31:0]   resp_addr;

   always #4 s_axi_aclk = ~s_axi_aclk;

   esaxi_top dut_i (
      .s_axi_aclk (s_axi_aclk), .s_axi_aresetn (s_axi_aresetn),
      .awid (awid), .awaddr (awaddr), .awlen (awlen), .awsize (awsize), .awburst (awburst),
      .awvalid (awvalid), .awready (awready),
      .wdata (wdata), .wstrb (wstrb), .wlast (wlast), .wvalid (wvalid), .wready (wready),
      .bid (bid), .bvalid (bvalid), .bready (bready),
      .arid (arid), .araddr (araddr), .arlen (arlen), .arsize (arsize), .arburst (arburst),
      .arvalid (arvalid), .arready (arready),
      .rid (rid), .rdata (rdata), .rlast (rlast), .rvalid (rvalid), .rready (rready),
      .tx_access (tx_access), .tx_packet (tx_packet), .tx_wait (tx_wait),
      .rxrr_access (rxrr_access), .rxrr_packet (rxrr_packet)
   );

   //##################################################
   // checks

   task automatic compare_value(input string name, input logic [102:0] exp,
                                input logic [102:0] got);
      n_checks++;
      assert (got === exp)
      else
      begin
         $display("Fail %0t %s expected %h got %h", $time, name, exp, got);
         n_errors++;
      end
   endtask

   function automatic emesh_packet_t make_packet(input logic wr, input logic [1:0] mode,
                                                 input logic [31:0] dst,
                                                 input logic [31:0] data,
                                                 input logic [31:0] src);
      emesh_packet_t p;
      p.write    = wr;
      p.datamode = mode;
      p.ctrlmode = 4'h0;
      p.dstaddr  = dst;
      p.data     = data;
      p.srcaddr  = src;
      return p;
   endfunction

   assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
                    tx_wait |-> !tx_access)
   else
   begin
      $display("tx_access was high while tx_wait was high at %0t", $time);
      n_errors++;
   end

   // response one cycle after the last beat
   assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
                    (wvalid && wready && wlast) |=> bvalid)
   else
   begin
      $display("bvalid did not follow the last write beat at %0t", $time);
      n_errors++;
   end

   assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
                    rxrr_access |=> rvalid)
   else
   begin
      $display("rvalid did not follow the read response at %0t", $time);
      n_errors++;
   end

   task automatic check_reset_outputs();
      compare_value("tx_access", 1'b0, tx_access);
      compare_value("bvalid", 1'b0, bvalid);
      compare_value("rvalid", 1'b0, rvalid);
      compare_value("wready", 1'b0, wready);
      compare_value("awready", 1'b1, awready);
      compare_value("arready", 1'b0, arready);
   endtask

   //##################################################
   // mesh side, monitor and responder

   always @(negedge s_axi_aclk)
   begin
      if (s_axi_aresetn)
      begin
         if (rvalid && rready)
            rd_outstanding = 1'b0;     // beat taken at the coming edge
         if (wvalid && wready)
            wr_in_flight++;
         if (tx_access && read_first)
         begin
            compare_value("tx_packet.write", 1'b0, tx_packet.write);   // read goes first
            read_first = 1'b0;
         end
         if (tx_access && tx_packet.write)
         begin
            wr_in_flight--;
            if (exp_wr.size() == 0)
            begin
               $display("unexpected write packet on the mesh at %0t", $time);
               n_errors++;
            end
            else
               compare_value("tx_packet", exp_wr.pop_front(), tx_packet);
         end
         else if (tx_access)
         begin
            n_checks++;
            assert (!rd_outstanding)
            else
            begin
               $display("second read packet sent before the beat was taken at %0t", $time);
               n_errors++;
            end
            rd_outstanding = 1'b1;
            if (exp_rd.size() == 0)
            begin
               $display("unexpected read packet on the mesh at %0t", $time);
               n_errors++;
            end
            else
               compare_value("tx_packet", exp_rd.pop_front(), tx_packet);
            resp_addr    = tx_packet.dstaddr;
            resp_delay   = $urandom_range(1, 6);
            resp_pending = 1'b1;
         end
         // queue entries plus the tx slot
         n_checks++;
         assert (wr_in_flight <= FIFO_DEPTH + 1)
         else
         begin
            $display("write path took more beats than it can hold at %0t", $time);
            n_errors++;
         end
      end
   end

   always @(posedge s_axi_aclk)
   begin
      #1;
      rxrr_access = 1'b0;
      if (resp_pending && resp_delay > 1)
         resp_delay--;
      else if (resp_pending)
      begin
         rxrr_access = 1'b1;
         rxrr_packet = make_packet(1'b1, 2'b10, 32'h999D_0000,
                                   resp_addr ^ 32'hA5A5_0000, 32'h0);  // data from the address
         resp_pending = 1'b0;
      end
      case (wait_mode)
         0:       tx_wait = 1'b0;
         1:       tx_wait = $urandom_range(0, 99) < 50;
         default: tx_wait = 1'b1;
      endcase
   end

   always @(posedge s_axi_aclk)
   begin
      cycle_cnt++;
      if (cycle_cnt == 2000)   // about four times the test sequence
      begin
         $display("run timed out after %0d cycles", cycle_cnt);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   //##################################################
   // axi driver

   task automatic write_burst(input axi_id_t id, input logic [31:0] addr,
                              input logic [2:0] size, input logic [3:0] strb, input int beats);
      int          b;
      int          lane;
      logic [31:0] data;
      logic [29:0] word;
      lane = strb[0] ? 0 : strb[1] ? 1 : strb[2] ? 2 : 3;   // lowest set lane
      word = addr[31:2];
      @(posedge s_axi_aclk);
      #1;
      awvalid = 1'b1;
      awid    = id;
      awaddr  = addr;
      awlen   = 8'(beats - 1);
      awsize  = size;
      awburst = 2'b01;   // incr
      @(negedge s_axi_aclk);
      while (!awready)
         @(negedge s_axi_aclk);
      @(posedge s_axi_aclk);
      #1;
      awvalid = 1'b0;
      for (b = 0; b < beats; b++)
      begin
         data   = $urandom;
         wvalid = 1'b1;
         wdata  = data;
         wstrb  = strb;
         wlast  = b == beats - 1;
         @(negedge s_axi_aclk);
         while (!wready)
            @(negedge s_axi_aclk);
         exp_wr.push_back(make_packet(1'b1, size[1:0], {word, 2'(lane)},
                                      data >> (8 * lane), 32'h0));
         word = word + 1'b1;   // next word
         @(posedge s_axi_aclk);
         #1;
      end
      wvalid = 1'b0;
      wlast  = 1'b0;
      @(negedge s_axi_aclk);
      compare_value("bvalid", 1'b1, bvalid);
      compare_value("bid", id, bid);
   endtask

   task automatic send_ar(input axi_id_t id, input logic [31:0] addr, input logic [7:0] len,
                          input logic [2:0] size);
      int          k;
      logic [31:0] a;
      logic [31:0] d;
      a = addr;
      for (k = 0; k <= len; k++)
      begin
         exp_rd.push_back(make_packet(1'b0, size[1:0], a, 32'h0, 32'h999D_0000));
         d = a ^ 32'hA5A5_0000;
         case (size)
            3'd0:    exp_rdata.push_back({4{d[7:0]}});
            3'd1:    exp_rdata.push_back({2{d[15:0]}});
            default: exp_rdata.push_back(d);
         endcase
         a = {a[31:2] + 30'd1, 2'b00};
      end
      @(posedge s_axi_aclk);
      #1;
      arvalid = 1'b1;
      arid    = id;
      araddr  = addr;
      arlen   = len;
      arsize  = size;
      arburst = 2'b01;
      @(negedge s_axi_aclk);
      while (!arready)
         @(negedge s_axi_aclk);
      @(posedge s_axi_aclk);
      #1;
      arvalid = 1'b0;
   endtask

   task automatic collect_r(input axi_id_t id, input int beats);
      int k;
      for (k = 0; k < beats; k++)
      begin
         @(negedge s_axi_aclk);
         while (!rvalid)
            @(negedge s_axi_aclk);
         compare_value("rdata", exp_rdata.pop_front(), rdata);
         compare_value("rlast", k == beats - 1, rlast);
         compare_value("rid", id, rid);
         @(posedge s_axi_aclk);   // rready held high
      end
   endtask

   task automatic wait_drain();
      @(posedge s_axi_aclk);
      while (exp_wr.size() != 0 || exp_rd.size() != 0 || resp_pending || rd_outstanding)
         @(posedge s_axi_aclk);
   endtask

   task automatic end_test(input string name);
      $display("test %s finished with %0d errors", name, n_errors - test_base);
      test_base = n_errors;
   endtask

   //##################################################
   // test sequence

   initial
   begin
      int i;
      void'($urandom(22476));
      s_axi_aresetn = 1'b0;
      {awid, awaddr, awlen, awsize, awburst, awvalid} = '0;
      {wdata, wstrb, wlast, wvalid} = '0;
      {arid, araddr, arlen, arsize, arburst, arvalid} = '0;
      bready      = 1'b1;
      rready      = 1'b1;
      tx_wait     = 1'b0;
      rxrr_access = 1'b0;
      rxrr_packet = '0;
      test_base   = 0;

      for (i = 0; i < 9; i++)
      begin
         @(negedge s_axi_aclk);
         check_reset_outputs();
      end
      @(posedge s_axi_aclk);
      #1;
      s_axi_aresetn = 1'b1;
      @(negedge s_axi_aclk);
      check_reset_outputs();   // first cycle out of reset
      end_test("reset state");

      for (i = 0; i < 4; i++)
         write_burst(12'h100 + 12'(i), 32'h2000_0010 + 32'(4 * i), 3'(i % 3),
                     4'hF << i, 1);
      wait_drain();
      end_test("strobe lanes");

      write_burst(12'h3A5, 32'h3000_0040, 3'd2, 4'hF, 4);
      wait_drain();
      end_test("incr write burst");

      for (i = 0; i < 3; i++)
      begin
         send_ar(12'h400 + 12'(i), 32'h4000_0100 + 32'(64 * i + 3 - i), 8'd2, 3'(i));
         collect_r(12'h400 + 12'(i), 3);
         wait_drain();
      end
      end_test("incr read bursts");

      wait_mode = 1;
      write_burst(12'h5C3, 32'h5000_0000, 3'd2, 4'hF, 8);
      send_ar(12'h5C4, 32'h5000_0200, 8'd2, 3'd2);
      collect_r(12'h5C4, 3);
      wait_drain();
      wait_mode = 0;
      end_test("back-pressure");

      wait_mode = 2;
      write_burst(12'h6A1, 32'h6000_0020, 3'd2, 4'hF, 2);
      send_ar(12'h6A2, 32'h6000_0300, 8'd0, 3'd2);
      repeat (4)
         @(posedge s_axi_aclk);   // request pushed two cycles after ar
      read_first = 1'b1;
      wait_mode  = 0;
      collect_r(12'h6A2, 1);
      wait_drain();
      end_test("read priority");

      $display("checks %0d errors %0d", n_checks, n_errors);
      if (n_errors == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

/* esaxi_top.f */
source/emesh_pkg.sv
source/axi_write_packetizer.sv
source/axi_read_packetizer.sv
source/mesh_request_fifo.sv
source/mesh_tx_arbiter.sv
source/esaxi_top.sv
verification/esaxi_top_tb.sv

/* Bender.yml */
package:
  name: esaxi_top

sources:
  - source/emesh_pkg.sv
  - source/axi_write_packetizer.sv
  - source/axi_read_packetizer.sv
  - source/mesh_request_fifo.sv
  - source/mesh_tx_arbiter.sv
  - source/esaxi_top.sv
  - target: test
    files:
      - verification/esaxi_top_tb.sv
